// ==== design/mem_geom_pkg.sv ====
/*
 * Memory-side geometry of the DDR3 I/O pad core.
 * Holds the DQS group count, the DQ width of one group and the
 * vector types that follow from them. Other files refer to these
 * items by scoped name.
 */
package mem_geom_pkg;

	// Two byte lanes, each with its own DQS strobe
	localparam int NUM_GROUPS = 2;
	localparam int GROUP_DQ_WIDTH = 8;

	localparam int MEM_DQ_WIDTH = NUM_GROUPS * GROUP_DQ_WIDTH;

	// Data of one group in one time slot
	typedef logic [GROUP_DQ_WIDTH-1:0] group_dq_t;

	// One bit per DQS group, used for VFIFO increments and group valids
	typedef logic [NUM_GROUPS-1:0] group_mask_t;

endpackage

// ==== design/afi_pkg.sv ====
/*
 * Controller-side AFI constants and types for the I/O pad core.
 * Covers the slot layout of a full-rate AFI cycle, the read latency
 * counter and the VFIFO shift and offset range. The data widths are
 * derived from the memory geometry package.
 */
package afi_pkg;

	localparam int AFI_SLOTS = 4;
	localparam int AFI_OE_SLOTS = 2;
	localparam int AFI_DATA_WIDTH = mem_geom_pkg::MEM_DQ_WIDTH * AFI_SLOTS;

	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [mem_geom_pkg::NUM_GROUPS*AFI_SLOTS-1:0] afi_dm_t;
	typedef logic [mem_geom_pkg::NUM_GROUPS*AFI_OE_SLOTS-1:0] afi_oe_t;

	// Read latency as set by the sequencer
	localparam int LAT_WIDTH = 5;
	typedef logic [LAT_WIDTH-1:0] rd_latency_t;

	localparam int EXTRA_VFIFO_SHIFT = 2;
	localparam int VFIFO_OFFSET_WIDTH = 2;
	typedef logic [VFIFO_OFFSET_WIDTH-1:0] vfifo_offset_t;

endpackage

// ==== design/write_lane_mapper.sv ====
/*
 * Write path lane mapper.
 * The AFI write bus arrives ordered by time slot, then by DQS group.
 * Each unit is moved to its group-major position and the result is
 * registered once, so every output lags its input by one cycle.
 */
`timescale 1ns/1ps

module write_lane_mapper (
	input  logic               pll_afi_clk,
	input  logic               reset_n_afi_clk,
	input  afi_pkg::afi_data_t phy_ddio_dq,
	input  afi_pkg::afi_dm_t   phy_ddio_wrdata_mask,
	input  afi_pkg::afi_oe_t   phy_ddio_wrdata_en,
	input  afi_pkg::afi_oe_t   phy_ddio_dqs_en,
	output afi_pkg::afi_data_t wr_dq,
	output afi_pkg::afi_dm_t   wr_dm,
	output afi_pkg::afi_oe_t   wr_oe,
	output afi_pkg::afi_oe_t   dqs_oe
);

	afi_pkg::afi_data_t dq_grp;
	afi_pkg::afi_dm_t   dm_grp;
	afi_pkg::afi_oe_t   wr_oe_grp;
	afi_pkg::afi_oe_t   dqs_oe_grp;

	genvar g, t, h;
	generate
		for (g = 0; g < mem_geom_pkg::NUM_GROUPS; g++) begin : gen_group
			for (t = 0; t < afi_pkg::AFI_SLOTS; t++) begin : gen_slot
				// Slot-major source index t*NUM_GROUPS+g, group-major target g*AFI_SLOTS+t
				mem_geom_pkg::group_dq_t unit_dq;

				assign unit_dq = phy_ddio_dq[(t*mem_geom_pkg::NUM_GROUPS+g)*
					mem_geom_pkg::GROUP_DQ_WIDTH +: mem_geom_pkg::GROUP_DQ_WIDTH];
				assign dq_grp[(g*afi_pkg::AFI_SLOTS+t)*mem_geom_pkg::GROUP_DQ_WIDTH +:
					mem_geom_pkg::GROUP_DQ_WIDTH] = unit_dq;
				assign dm_grp[g*afi_pkg::AFI_SLOTS+t] =
					phy_ddio_wrdata_mask[t*mem_geom_pkg::NUM_GROUPS+g];
			end
			for (h = 0; h < afi_pkg::AFI_OE_SLOTS; h++) begin : gen_half
				assign wr_oe_grp[g*afi_pkg::AFI_OE_SLOTS+h] =
					phy_ddio_wrdata_en[h*mem_geom_pkg::NUM_GROUPS+g];
				assign dqs_oe_grp[g*afi_pkg::AFI_OE_SLOTS+h] =
					phy_ddio_dqs_en[h*mem_geom_pkg::NUM_GROUPS+g];
			end
		end
	endgenerate

	// Core-to-periphery register
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wr_dq  <= '0;
			wr_dm  <= '0;
			wr_oe  <= '0;
			dqs_oe <= '0;
		end else begin
			wr_dq  <= dq_grp;
			wr_dm  <= dm_grp;
			wr_oe  <= wr_oe_grp;
			dqs_oe <= dqs_oe_grp;
		end
	end

endmodule

// ==== design/read_enable_pipe.sv ====
/*
 * Read enable delay pipe.
 * A fixed shift of SHIFT_DEPTH cycles feeds a 32-entry latency line.
 * The tap chosen by the sequencer latency L gives a total delay of
 * SHIFT_DEPTH plus L cycles. L is valid from 1 upward.
 */
`timescale 1ns/1ps

module read_enable_pipe #(
	parameter int SHIFT_DEPTH = afi_pkg::EXTRA_VFIFO_SHIFT
) (
	input  logic                 pll_afi_clk,
	input  logic                 reset_n_afi_clk,
	input  logic                 afi_rdata_en_full,
	input  afi_pkg::rd_latency_t seq_read_latency_counter,
	output logic                 rd_en_tap
);

	logic                                 en_shifted;
	logic [(2**afi_pkg::LAT_WIDTH)-1:0]   lat_line;
	afi_pkg::rd_latency_t                 tap_sel;

	generate
		if (SHIFT_DEPTH > 0) begin : gen_shift
			logic [SHIFT_DEPTH-1:0] extra_shift;

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					extra_shift <= '0;
				end else begin
					extra_shift[0] <= afi_rdata_en_full;
					for (int i = 1; i < SHIFT_DEPTH; i++) begin
						extra_shift[i] <= extra_shift[i-1];
					end
				end
			end
			assign en_shifted = extra_shift[SHIFT_DEPTH-1];
		end else begin : gen_no_shift
			assign en_shifted = afi_rdata_en_full;
		end
	endgenerate

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			lat_line <= '0;
		end else begin
			lat_line <= {lat_line[(2**afi_pkg::LAT_WIDTH)-2:0], en_shifted};
		end
	end

	// Entry 0 already holds one cycle of latency
	assign tap_sel   = seq_read_latency_counter - afi_pkg::rd_latency_t'(1);
	assign rd_en_tap = lat_line[tap_sel];

endmodule

// ==== design/group_vfifo_align.sv ====
/*
 * VFIFO alignment for one DQS group.
 * A 2-bit offset counter steps on each increment pulse and wraps
 * from 3 to 0; a clear pulse returns it to 0. The offset picks the
 * read enable delayed by that many cycles.
 */
`timescale 1ns/1ps

module group_vfifo_align (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic rd_en_tap,
	input  logic vfifo_inc,
	input  logic vfifo_clear,
	output logic group_valid
);

	afi_pkg::vfifo_offset_t offset;
	logic [2:0]             en_hist;
	logic [3:0]             en_taps;

	// Clear wins over an increment in the same cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			offset <= '0;
		end else if (vfifo_clear) begin
			offset <= '0;
		end else if (vfifo_inc) begin
			offset <= offset + afi_pkg::vfifo_offset_t'(1);
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			en_hist <= '0;
		end else begin
			en_hist <= {en_hist[1:0], rd_en_tap};
		end
	end

	// Offset 0 selects the undelayed enable
	assign en_taps     = {en_hist, rd_en_tap};
	assign group_valid = en_taps[offset];

endmodule

// ==== design/read_valid_path.sv ====
/*
 * Read valid generation across DQS groups.
 * Every group delays the latency-aligned read enable by its own VFIFO
 * offset. The AFI read valid is the registered AND of all group
 * valids, so it rises only where every group agrees.
 */
`timescale 1ns/1ps

module read_valid_path (
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  logic                      rd_en_tap,
	input  mem_geom_pkg::group_mask_t seq_read_increment_vfifo,
	input  logic                      seq_read_fifo_reset,
	output logic                      afi_rdata_valid
);

	mem_geom_pkg::group_mask_t group_valid;

	genvar g;
	generate
		for (g = 0; g < mem_geom_pkg::NUM_GROUPS; g++) begin : gen_group
			group_vfifo_align group_vfifo_align_inst (
				.pll_afi_clk     (pll_afi_clk),
				.reset_n_afi_clk (reset_n_afi_clk),
				.rd_en_tap       (rd_en_tap),
				.vfifo_inc       (seq_read_increment_vfifo[g]),
				.vfifo_clear     (seq_read_fifo_reset),
				.group_valid     (group_valid[g])
			);
		end
	endgenerate

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= 1'b0;
		end else begin
			afi_rdata_valid <= &group_valid;
		end
	end

endmodule

// ==== design/io_pads_top.sv ====
/*
 * Digital core of the DDR3 PHY I/O pad block.
 * The write path re-registers the AFI write bus into group-major
 * order for the memory side. The read path turns the full-rate read
 * enable into the AFI read valid, using the sequencer's latency
 * setting and per-group VFIFO offsets.
 */
`timescale 1ns/1ps

module io_pads_top (
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,

	input  afi_pkg::afi_data_t        phy_ddio_dq,
	input  afi_pkg::afi_dm_t          phy_ddio_wrdata_mask,
	input  afi_pkg::afi_oe_t          phy_ddio_wrdata_en,
	input  afi_pkg::afi_oe_t          phy_ddio_dqs_en,

	input  logic                      afi_rdata_en_full,
	input  afi_pkg::rd_latency_t      seq_read_latency_counter,
	input  mem_geom_pkg::group_mask_t seq_read_increment_vfifo,
	input  logic                      seq_read_fifo_reset,

	output afi_pkg::afi_data_t        wr_dq,
	output afi_pkg::afi_dm_t          wr_dm,
	output afi_pkg::afi_oe_t          wr_oe,
	output afi_pkg::afi_oe_t          dqs_oe,

	output logic                      afi_rdata_valid
);

	// Read enable after the extra shift and the latency line
	logic rd_en_tap;

	write_lane_mapper write_lane_mapper_inst (
		.pll_afi_clk          (pll_afi_clk),
		.reset_n_afi_clk      (reset_n_afi_clk),
		.phy_ddio_dq          (phy_ddio_dq),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en   (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en      (phy_ddio_dqs_en),
		.wr_dq                (wr_dq),
		.wr_dm                (wr_dm),
		.wr_oe                (wr_oe),
		.dqs_oe               (dqs_oe)
	);

	read_enable_pipe #(
		.SHIFT_DEPTH (afi_pkg::EXTRA_VFIFO_SHIFT)
	) read_enable_pipe_inst (
		.pll_afi_clk              (pll_afi_clk),
		.reset_n_afi_clk          (reset_n_afi_clk),
		.afi_rdata_en_full        (afi_rdata_en_full),
		.seq_read_latency_counter (seq_read_latency_counter),
		.rd_en_tap                (rd_en_tap)
	);

	read_valid_path read_valid_path_inst (
		.pll_afi_clk              (pll_afi_clk),
		.reset_n_afi_clk          (reset_n_afi_clk),
		.rd_en_tap                (rd_en_tap),
		.seq_read_increment_vfifo (seq_read_increment_vfifo),
		.seq_read_fifo_reset      (seq_read_fifo_reset),
		.afi_rdata_valid          (afi_rdata_valid)
	);

endmodule

// ==== tb/io_pads_chk.sv ====
/*
 * Assertions on the I/O pad core, bound to io_pads_top.
 * Covers the read valid around reset and the write output enables
 * following their AFI enables by one cycle.
 */
`timescale 1ns/1ps

module io_pads_chk (
	input logic             pll_afi_clk,
	input logic             reset_n_afi_clk,
	input afi_pkg::afi_oe_t phy_ddio_wrdata_en,
	input afi_pkg::afi_oe_t phy_ddio_dqs_en,
	input afi_pkg::afi_oe_t wr_oe,
	input afi_pkg::afi_oe_t dqs_oe,
	input logic             afi_rdata_valid
);

	int assert_failures = 0;

	valid_low_in_reset: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> !afi_rdata_valid)
		else begin
			$error("afi_rdata_valid is high while reset is asserted");
			assert_failures++;
		end

	// The read pipe is at least four stages deep, so valid stays low after reset
	valid_low_after_reset: assert property (@(posedge pll_afi_clk)
		$rose(reset_n_afi_clk) |-> (!afi_rdata_valid) [*3])
		else begin
			$error("afi_rdata_valid rose within 3 cycles of reset release");
			assert_failures++;
		end

	wr_oe_follows_en: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(phy_ddio_wrdata_en == '0) |=> (wr_oe == '0))
		else begin
			$error("wr_oe is set one cycle after an all-zero write enable");
			assert_failures++;
		end

	dqs_oe_follows_en: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(phy_ddio_dqs_en == '0) |=> (dqs_oe == '0))
		else begin
			$error("dqs_oe is set one cycle after an all-zero DQS enable");
			assert_failures++;
		end

endmodule

// ==== tb/tb_io_pads.sv ====
/*
 * Testbench for the DDR3 I/O pad core.
 * Walks a table of test entries, each run for a fixed number of cycles.
 * The write lane order and the AFI read valid are compared every cycle
 * against a reference model built from the lane order and delay rules.
 */
`timescale 1ns/1ps

module tb_io_pads;

	localparam int TABLE_LEN = 11;
	localparam int ENTRY_STEPS = 48;
	localparam int MAX_STEPS = TABLE_LEN * ENTRY_STEPS;
	localparam int WATCHDOG_CYCLES = TABLE_LEN * 64 + 200;
	localparam int NG = mem_geom_pkg::NUM_GROUPS;
	localparam int GW = mem_geom_pkg::GROUP_DQ_WIDTH;

	logic                      pll_afi_clk;
	logic                      reset_n_afi_clk;
	afi_pkg::afi_data_t        phy_ddio_dq;
	afi_pkg::afi_dm_t          phy_ddio_wrdata_mask;
	afi_pkg::afi_oe_t          phy_ddio_wrdata_en;
	afi_pkg::afi_oe_t          phy_ddio_dqs_en;
	logic                      afi_rdata_en_full;
	afi_pkg::rd_latency_t      seq_read_latency_counter;
	mem_geom_pkg::group_mask_t seq_read_increment_vfifo;
	logic                      seq_read_fifo_reset;
	afi_pkg::afi_data_t        wr_dq;
	afi_pkg::afi_dm_t          wr_dm;
	afi_pkg::afi_oe_t          wr_oe;
	afi_pkg::afi_oe_t          dqs_oe;
	logic                      afi_rdata_valid;

	// Stimulus table, one column per array
	string                     t_name [TABLE_LEN];
	bit                        t_wr_random [TABLE_LEN];
	afi_pkg::afi_oe_t          t_oe_fix [TABLE_LEN];
	afi_pkg::rd_latency_t      t_lat [TABLE_LEN];
	mem_geom_pkg::group_mask_t t_inc_mask [TABLE_LEN];
	int                        t_inc_count [TABLE_LEN];
	bit                        t_clear [TABLE_LEN];
	logic [3:0]                t_en_pattern [TABLE_LEN];
	int                        t_exp_valids [TABLE_LEN];

	// Reference model state, indexed by step
	logic                      en_log [MAX_STEPS];
	afi_pkg::vfifo_offset_t    off_log [MAX_STEPS][NG];
	afi_pkg::vfifo_offset_t    off_model [NG];
	afi_pkg::afi_data_t        last_dq;
	afi_pkg::afi_dm_t          last_dm;
	afi_pkg::afi_oe_t          last_wr_en;
	afi_pkg::afi_oe_t          last_dqs_en;
	afi_pkg::rd_latency_t      cur_lat;

	int seed;
	int n_entries;
	int reset_errors;
	int write_errors;
	int read_errors;
	int assert_errors;

	io_pads_top io_pads_top_inst (.*);

	bind io_pads_top io_pads_chk io_pads_chk_inst (
		.pll_afi_clk        (pll_afi_clk),
		.reset_n_afi_clk    (reset_n_afi_clk),
		.phy_ddio_wrdata_en (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en    (phy_ddio_dqs_en),
		.wr_oe              (wr_oe),
		.dqs_oe             (dqs_oe),
		.afi_rdata_valid    (afi_rdata_valid)
	);

	always #5 pll_afi_clk = ~pll_afi_clk;

	task automatic add_entry(input string name, input bit wr_random, input afi_pkg::afi_oe_t oe,
		input afi_pkg::rd_latency_t lat, input mem_geom_pkg::group_mask_t inc_mask,
		input int inc_count, input bit clear, input logic [3:0] en_pattern, input int valids);
		t_name[n_entries] = name;
		t_wr_random[n_entries] = wr_random;
		t_oe_fix[n_entries] = oe;
		t_lat[n_entries] = lat;
		t_inc_mask[n_entries] = inc_mask;
		t_inc_count[n_entries] = inc_count;
		t_clear[n_entries] = clear;
		t_en_pattern[n_entries] = en_pattern;
		t_exp_valids[n_entries] = valids;
		n_entries++;
	endtask

	// Slot-major t*NG+g in, group-major g*AFI_SLOTS+t out
	function automatic afi_pkg::afi_data_t reorder_dq(input afi_pkg::afi_data_t dq);
		afi_pkg::afi_data_t r;
		int g;
		int t;
		for (g = 0; g < NG; g++) begin
			for (t = 0; t < afi_pkg::AFI_SLOTS; t++) begin
				r[(g*afi_pkg::AFI_SLOTS+t)*GW +: GW] = dq[(t*NG+g)*GW +: GW];
			end
		end
		return r;
	endfunction

	function automatic afi_pkg::afi_dm_t reorder_dm(input afi_pkg::afi_dm_t dm);
		afi_pkg::afi_dm_t r;
		int g;
		int t;
		for (g = 0; g < NG; g++) begin
			for (t = 0; t < afi_pkg::AFI_SLOTS; t++) begin
				r[g*afi_pkg::AFI_SLOTS+t] = dm[t*NG+g];
			end
		end
		return r;
	endfunction

	function automatic afi_pkg::afi_oe_t reorder_oe(input afi_pkg::afi_oe_t oe);
		afi_pkg::afi_oe_t r;
		int g;
		int h;
		for (g = 0; g < NG; g++) begin
			for (h = 0; h < afi_pkg::AFI_OE_SLOTS; h++) begin
				r[g*afi_pkg::AFI_OE_SLOTS+h] = oe[h*NG+g];
			end
		end
		return r;
	endfunction

	// Enable of step k is seen at k+3+L+offset; the offset in use dates from two steps back
	function automatic logic expected_valid(input int s);
		logic v;
		int g;
		int src;
		v = 1'b1;
		for (g = 0; g < NG; g++) begin
			src = s - 3 - int'(cur_lat) - ((s >= 2) ? int'(off_log[s-2][g]) : 0);
			v = v & ((src >= 0) ? en_log[src] : 1'b0);
		end
		return v;
	endfunction

	task automatic check_outputs(input int e, input int s);
		logic exp_valid;
		exp_valid = expected_valid(s);
		if (wr_dq !== reorder_dq(last_dq)) begin
			$display("ERROR %s wr_dq: expected %h, actual %h", t_name[e], reorder_dq(last_dq),
				wr_dq);
			write_errors++;
		end
		if (wr_dm !== reorder_dm(last_dm)) begin
			$display("ERROR %s wr_dm: expected %h, actual %h", t_name[e], reorder_dm(last_dm),
				wr_dm);
			write_errors++;
		end
		if (wr_oe !== reorder_oe(last_wr_en)) begin
			$display("ERROR %s wr_oe: expected %h, actual %h", t_name[e], reorder_oe(last_wr_en),
				wr_oe);
			write_errors++;
		end
		if (dqs_oe !== reorder_oe(last_dqs_en)) begin
			$display("ERROR %s dqs_oe: expected %h, actual %h", t_name[e], reorder_oe(last_dqs_en),
				dqs_oe);
			write_errors++;
		end
		if (afi_rdata_valid !== exp_valid) begin
			$display("ERROR %s afi_rdata_valid at step %0d: expected %b, actual %b", t_name[e], s,
				exp_valid, afi_rdata_valid);
			read_errors++;
		end
	endtask

	task automatic drive_step(input int e, input int i, input int s);
		int g;
		if (t_wr_random[e]) begin
			phy_ddio_dq = {$random(seed), $random(seed)};
			phy_ddio_wrdata_mask = afi_pkg::afi_dm_t'($random(seed));
			phy_ddio_wrdata_en = afi_pkg::afi_oe_t'($random(seed));
			phy_ddio_dqs_en = afi_pkg::afi_oe_t'($random(seed));
		end else begin
			phy_ddio_dq = '0;
			phy_ddio_wrdata_mask = '0;
			phy_ddio_wrdata_en = t_oe_fix[e];
			phy_ddio_dqs_en = ~t_oe_fix[e];
		end
		seq_read_latency_counter = t_lat[e];
		seq_read_fifo_reset = t_clear[e] && (i == 0);
		seq_read_increment_vfifo = (i >= 1 && i <= t_inc_count[e]) ? t_inc_mask[e] : '0;
		afi_rdata_en_full = (i >= 8 && i < 12) ? t_en_pattern[e][i-8] : 1'b0;
		// The 2-bit model offset wraps from 3 to 0 by itself
		for (g = 0; g < NG; g++) begin
			if (seq_read_fifo_reset) begin
				off_model[g] = '0;
			end else if (seq_read_increment_vfifo[g]) begin
				off_model[g] = off_model[g] + 1'b1;
			end
			off_log[s][g] = off_model[g];
		end
		en_log[s] = afi_rdata_en_full;
		last_dq = phy_ddio_dq;
		last_dm = phy_ddio_wrdata_mask;
		last_wr_en = phy_ddio_wrdata_en;
		last_dqs_en = phy_ddio_dqs_en;
		cur_lat = t_lat[e];
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge pll_afi_clk);
		$display("Watchdog: the test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int e;
		int i;
		int step;
		int valids_seen;
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		phy_ddio_dq = '0;
		phy_ddio_wrdata_mask = '0;
		phy_ddio_wrdata_en = '0;
		phy_ddio_dqs_en = '0;
		afi_rdata_en_full = 1'b0;
		seq_read_latency_counter = afi_pkg::rd_latency_t'(1);
		seq_read_increment_vfifo = '0;
		seq_read_fifo_reset = 1'b0;
		seed = 37361;
		n_entries = 0;
		reset_errors = 0;
		write_errors = 0;
		read_errors = 0;
		assert_errors = 0;
		last_dq = '0;
		last_dm = '0;
		last_wr_en = '0;
		last_dqs_en = '0;
		cur_lat = afi_pkg::rd_latency_t'(1);
		off_model = '{default: '0};

		add_entry("write_reorder", 1'b1, 4'h0, 5'd1, 2'b00, 0, 1'b0, 4'b0000, 0);
		add_entry("write_oe_fixed", 1'b0, 4'h5, 5'd1, 2'b00, 0, 1'b0, 4'b0000, 0);
		add_entry("base_lat_1", 1'b0, 4'h0, 5'd1, 2'b00, 0, 1'b0, 4'b0001, 1);
		add_entry("base_lat_7", 1'b1, 4'h0, 5'd7, 2'b00, 0, 1'b0, 4'b0001, 1);
		add_entry("base_lat_24", 1'b1, 4'h0, 5'd24, 2'b00, 0, 1'b0, 4'b0001, 1);
		add_entry("equal_offset_1", 1'b1, 4'h0, 5'd7, 2'b11, 1, 1'b0, 4'b0001, 1);
		add_entry("equal_offset_wrap", 1'b1, 4'h0, 5'd7, 2'b11, 3, 1'b0, 4'b0001, 1);
		add_entry("unequal_single", 1'b1, 4'h0, 5'd5, 2'b01, 1, 1'b0, 4'b0001, 0);
		add_entry("unequal_run3", 1'b1, 4'h0, 5'd5, 2'b00, 0, 1'b0, 4'b0111, 2);
		add_entry("offset_clear", 1'b1, 4'h0, 5'd5, 2'b00, 0, 1'b1, 4'b0001, 1);
		add_entry("offset_2_lat_24", 1'b1, 4'h0, 5'd24, 2'b11, 2, 1'b0, 4'b0101, 2);

		repeat (5) begin
			@(posedge pll_afi_clk);
			#1;
			if (wr_oe !== '0 || dqs_oe !== '0 || afi_rdata_valid !== 1'b0) begin
				$display("ERROR reset_state: expected 0, actual wr_oe=%h dqs_oe=%h valid=%b",
					wr_oe, dqs_oe, afi_rdata_valid);
				reset_errors++;
			end
		end
		reset_n_afi_clk = 1'b1;

		step = 0;
		for (e = 0; e < TABLE_LEN; e++) begin
			valids_seen = 0;
			for (i = 0; i < ENTRY_STEPS; i++) begin
				@(posedge pll_afi_clk);
				#1;
				check_outputs(e, step);
				if (afi_rdata_valid === 1'b1) begin
					valids_seen++;
				end
				drive_step(e, i, step);
				step++;
			end
			if (valids_seen != t_exp_valids[e]) begin
				$display("ERROR %s valid count: expected %0d, actual %0d", t_name[e],
					t_exp_valids[e], valids_seen);
				read_errors++;
			end
		end

		assert_errors = io_pads_top_inst.io_pads_chk_inst.assert_failures;
		$display("Error counts: reset %0d, write %0d, read %0d, assertion %0d", reset_errors,
			write_errors, read_errors, assert_errors);
		if (reset_errors + write_errors + read_errors + assert_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
design/mem_geom_pkg.sv
design/afi_pkg.sv
design/write_lane_mapper.sv
design/read_enable_pipe.sv
design/group_vfifo_align.sv
design/read_valid_path.sv
design/io_pads_top.sv
tb/io_pads_chk.sv
tb/tb_io_pads.sv

// ==== Bender.yml ====
package:
  name: io_pads

sources:
  - files:
      - design/mem_geom_pkg.sv
      - design/afi_pkg.sv
      - design/write_lane_mapper.sv
      - design/read_enable_pipe.sv
      - design/group_vfifo_align.sv
      - design/read_valid_path.sv
      - design/io_pads_top.sv
  - target: test
    files:
      - tb/io_pads_chk.sv
      - tb/tb_io_pads.sv
